// ==== miner_pkg.sv ====
package miner_pkg;

	// the initial state is a 256-bit midstate followed by the 96-bit header tail
	localparam int STATE_W = 352;

	// the host delivers the state one byte at a time
	localparam int CHUNK_W = 8;
	localparam int NUM_CHUNKS = STATE_W / CHUNK_W;

	// nonce and block sequence widths seen by the hash cores
	localparam int NONCE_W = 32;
	localparam int SEQ_W = 8;

	// register byte offsets inside the 4-bit AXI4-Lite address space
	localparam logic [3:0] ADDR_CHUNK = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;
	localparam logic [3:0] ADDR_BLOCKS = 4'h8;

	// the loader FSM either collects bytes or hands the state to every lane
	typedef enum logic {
		LOAD_CHUNKS,
		BROADCAST
	} loader_state_e;

	// write channel FSM of the register block
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_HOLD,
		WR_RESP
	} axil_wr_state_e;

endpackage

// ==== miner_regs.sv ====
`timescale 1ns/1ps

module miner_regs (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic [3:0]                    s_axil_awaddr_i,
	input  logic                          s_axil_awvalid_i,
	output logic                          s_axil_awready_o,
	input  logic [31:0]                   s_axil_wdata_i,
	input  logic [3:0]                    s_axil_wstrb_i,
	input  logic                          s_axil_wvalid_i,
	output logic                          s_axil_wready_o,
	output logic [1:0]                    s_axil_bresp_o,
	output logic                          s_axil_bvalid_o,
	input  logic                          s_axil_bready_i,
	input  logic [3:0]                    s_axil_araddr_i,
	input  logic                          s_axil_arvalid_i,
	output logic                          s_axil_arready_o,
	output logic [31:0]                   s_axil_rdata_o,
	output logic [1:0]                    s_axil_rresp_o,
	output logic                          s_axil_rvalid_o,
	input  logic                          s_axil_rready_i,
	output logic                          chunk_valid_o,
	output logic [miner_pkg::CHUNK_W-1:0] chunk_data_o,
	input  logic                          chunk_ready_i,
	input  logic [5:0]                    chunk_count_i,
	input  logic                          bcast_active_i,
	input  logic                          block_done_i
);
	import miner_pkg::*;

	axil_wr_state_e wr_state_q;
	logic aw_seen_q;
	logic w_seen_q;
	logic [3:0] aw_addr_q;
	logic [31:0] w_data_q;
	logic [3:0] w_strb_q;
	logic aw_fire;
	logic w_fire;
	logic wr_go;
	logic [3:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0] wr_strb;
	logic chunk_valid_q;
	logic [CHUNK_W-1:0] chunk_data_q;
	logic [31:0] block_count_q;
	logic ar_fire;
	logic rvalid_q;
	logic [31:0] rdata_q;
	logic [31:0] status_word;
	logic [31:0] read_word;

	// each write channel is taken once in idle, so AW and W may arrive apart
	assign s_axil_awready_o = (wr_state_q == WR_IDLE) && !aw_seen_q;
	assign s_axil_wready_o = (wr_state_q == WR_IDLE) && !w_seen_q;
	assign aw_fire = s_axil_awvalid_i && s_axil_awready_o;
	assign w_fire = s_axil_wvalid_i && s_axil_wready_o;

	// use the captured half if it came early, else the one on the bus now
	assign wr_addr = aw_seen_q ? aw_addr_q : s_axil_awaddr_i;
	assign wr_data = w_seen_q ? w_data_q : s_axil_wdata_i;
	assign wr_strb = w_seen_q ? w_strb_q : s_axil_wstrb_i;
	assign wr_go = (wr_state_q == WR_IDLE) && (aw_seen_q || aw_fire) && (w_seen_q || w_fire);

	// every access is answered with OKAY, unmapped ones included
	assign s_axil_bresp_o = 2'b00;
	assign s_axil_bvalid_o = (wr_state_q == WR_RESP);
	assign s_axil_rresp_o = 2'b00;

	assign chunk_valid_o = chunk_valid_q;
	assign chunk_data_o = chunk_data_q;

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			aw_addr_q <= s_axil_awaddr_i;
		end
		if (w_fire) begin
			w_data_q <= s_axil_wdata_i;
			w_strb_q <= s_axil_wstrb_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_state_q <= WR_IDLE;
			aw_seen_q <= 1'b0;
			w_seen_q <= 1'b0;
			chunk_valid_q <= 1'b0;
		end else begin
			case (wr_state_q)
				WR_IDLE: begin
					if (wr_go) begin
						aw_seen_q <= 1'b0;
						w_seen_q <= 1'b0;
						// a chunk write waits for the loader before the host gets its response
						if (wr_addr[3:2] == ADDR_CHUNK[3:2] && wr_strb[0]) begin
							chunk_valid_q <= 1'b1;
							wr_state_q <= WR_HOLD;
						end else begin
							wr_state_q <= WR_RESP;
						end
					end else begin
						aw_seen_q <= aw_seen_q || aw_fire;
						w_seen_q <= w_seen_q || w_fire;
					end
				end
				WR_HOLD: begin
					if (chunk_ready_i) begin
						chunk_valid_q <= 1'b0;
						wr_state_q <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (s_axil_bready_i) begin
						wr_state_q <= WR_IDLE;
					end
				end
				default: begin
					wr_state_q <= WR_IDLE;
				end
			endcase
		end
	end

	// only the low byte of the written word is kept
	always_ff @(posedge clk) begin
		if (wr_go) begin
			chunk_data_q <= wr_data[CHUNK_W-1:0];
		end
	end

	// completed blocks as reported by the loader
	always_ff @(posedge clk) begin
		if (reset_i) begin
			block_count_q <= '0;
		end else if (block_done_i) begin
			block_count_q <= block_count_q + 32'd1;
		end
	end

	// loader ready in bit 0, chunk count in 13:8, broadcast active in bit 16
	assign status_word = {15'd0, bcast_active_i, 2'd0, chunk_count_i, 7'd0, chunk_ready_i};

	always_comb begin
		if (s_axil_araddr_i[3:2] == ADDR_STATUS[3:2]) begin
			read_word = status_word;
		end else if (s_axil_araddr_i[3:2] == ADDR_BLOCKS[3:2]) begin
			read_word = block_count_q;
		end else begin
			read_word = '0;
		end
	end

	// one read in flight, a new address is taken only after the data is gone
	assign s_axil_arready_o = !rvalid_q;
	assign ar_fire = s_axil_arvalid_i && s_axil_arready_o;
	assign s_axil_rvalid_o = rvalid_q;
	assign s_axil_rdata_o = rdata_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rvalid_q <= 1'b0;
		end else if (ar_fire) begin
			rvalid_q <= 1'b1;
		end else if (s_axil_rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata_q <= read_word;
		end
	end

endmodule

// ==== block_storage.sv ====
`timescale 1ns/1ps

module block_storage #(
	parameter int NUM_LANES = 16,
	localparam int LANE_W = $clog2(NUM_LANES)
) (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          chunk_valid_i,
	input  logic [miner_pkg::CHUNK_W-1:0] chunk_data_i,
	output logic                          chunk_ready_o,
	output logic [5:0]                    chunk_count_o,
	output logic                          bcast_active_o,
	output logic                          block_done_o,
	output logic                          bcast_valid_o,
	input  logic                          bcast_ready_i,
	output logic [miner_pkg::STATE_W-1:0] bcast_state_o,
	output logic [LANE_W-1:0]             bcast_lane_o,
	output logic                          bcast_first_o
);
	import miner_pkg::*;

	loader_state_e state_q;
	logic [5:0] chunk_idx_q;
	logic [STATE_W-1:0] block_q;
	logic [LANE_W-1:0] lane_q;
	logic chunk_fire;
	logic bcast_fire;
	logic last_chunk;
	logic last_lane;

	// bytes are only taken while loading, the broadcast phase blocks the host
	assign chunk_ready_o = (state_q == LOAD_CHUNKS);
	assign bcast_valid_o = (state_q == BROADCAST);
	assign bcast_active_o = bcast_valid_o;

	assign chunk_fire = chunk_valid_i && chunk_ready_o;
	assign bcast_fire = bcast_valid_o && bcast_ready_i;

	assign last_chunk = (chunk_idx_q == 6'(NUM_CHUNKS - 1));
	assign last_lane = (lane_q == LANE_W'(NUM_LANES - 1));

	// the chunk index doubles as the count reported to the host
	// it sits at 44 for the whole broadcast phase
	assign chunk_count_o = chunk_idx_q;

	// the same assembled state goes out on every lane, only the lane number moves
	assign bcast_state_o = block_q;
	assign bcast_lane_o = lane_q;
	assign bcast_first_o = (lane_q == '0);

	// one pulse when the last lane of the block is handed over
	assign block_done_o = bcast_fire && last_lane;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= LOAD_CHUNKS;
			chunk_idx_q <= '0;
			lane_q <= '0;
		end else begin
			case (state_q)
				LOAD_CHUNKS: begin
					if (chunk_fire) begin
						chunk_idx_q <= chunk_idx_q + 6'd1;
						// the 44th byte completes the state, broadcast starts next cycle
						if (last_chunk) begin
							state_q <= BROADCAST;
						end
					end
				end
				BROADCAST: begin
					// a stalled lane simply holds, nothing advances without ready
					if (bcast_fire) begin
						if (last_lane) begin
							state_q <= LOAD_CHUNKS;
							chunk_idx_q <= '0;
							lane_q <= '0;
						end else begin
							lane_q <= lane_q + LANE_W'(1);
						end
					end
				end
				default: begin
					state_q <= LOAD_CHUNKS;
				end
			endcase
		end
	end

	// chunk k fills bits 351-8k down to 344-8k, so the first byte is the top byte
	always_ff @(posedge clk) begin
		if (chunk_fire) begin
			block_q[STATE_W - 1 - CHUNK_W * int'(chunk_idx_q) -: CHUNK_W] <= chunk_data_i;
		end
	end

endmodule

// ==== work_dispatch.sv ====
`timescale 1ns/1ps

module work_dispatch #(
	parameter int NUM_LANES = 16,
	localparam int LANE_W = $clog2(NUM_LANES)
) (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          bcast_valid_i,
	output logic                          bcast_ready_o,
	input  logic [miner_pkg::STATE_W-1:0] bcast_state_i,
	input  logic [LANE_W-1:0]             bcast_lane_i,
	input  logic                          bcast_first_i,
	output logic                          work_valid_o,
	input  logic                          work_ready_i,
	output logic [miner_pkg::STATE_W-1:0] work_state_o,
	output logic [LANE_W-1:0]             work_lane_o,
	output logic [miner_pkg::NONCE_W-1:0] work_nonce_o,
	output logic [miner_pkg::SEQ_W-1:0]   work_seq_o,
	output logic                          work_first_o
);
	import miner_pkg::*;

	// each lane owns an equal slice of the 2^32 nonce space
	localparam logic [NONCE_W-1:0] NONCE_STEP = NONCE_W'((64'd1 << NONCE_W) / NUM_LANES);

	logic [STATE_W-1:0] state_mem [2];
	logic [LANE_W-1:0] lane_mem [2];
	logic [NONCE_W-1:0] nonce_mem [2];
	logic first_mem [2];
	logic wr_ptr_q;
	logic rd_ptr_q;
	logic [1:0] count_q;
	logic [SEQ_W-1:0] seq_q;
	logic in_fire;
	logic out_fire;
	logic [NONCE_W-1:0] nonce_in;

	// room is left while at least one of the two entries is free
	assign bcast_ready_o = (count_q != 2'd2);
	assign in_fire = bcast_valid_i && bcast_ready_o;

	assign work_valid_o = (count_q != 2'd0);
	assign out_fire = work_valid_o && work_ready_i;

	// the base nonce is worked out on entry so the output sees registers only
	assign nonce_in = NONCE_W'(bcast_lane_i) * NONCE_STEP;

	always_ff @(posedge clk) begin
		if (in_fire) begin
			state_mem[wr_ptr_q] <= bcast_state_i;
			lane_mem[wr_ptr_q] <= bcast_lane_i;
			nonce_mem[wr_ptr_q] <= nonce_in;
			first_mem[wr_ptr_q] <= bcast_first_i;
		end
	end

	// the head entry stays put until the cores take it
	assign work_state_o = state_mem[rd_ptr_q];
	assign work_lane_o = lane_mem[rd_ptr_q];
	assign work_nonce_o = nonce_mem[rd_ptr_q];
	assign work_first_o = first_mem[rd_ptr_q];

	// the sequence number is applied at the head, so items already queued
	// for the next block pick up the new value once the last lane has left
	assign work_seq_o = seq_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q <= '0;
			seq_q <= '0;
		end else begin
			if (in_fire) begin
				wr_ptr_q <= !wr_ptr_q;
			end
			if (out_fire) begin
				rd_ptr_q <= !rd_ptr_q;
				if (work_lane_o == LANE_W'(NUM_LANES - 1)) begin
					seq_q <= seq_q + SEQ_W'(1);
				end
			end
			case ({in_fire, out_fire})
				2'b10: count_q <= count_q + 2'd1;
				2'b01: count_q <= count_q - 2'd1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== miner_top.sv ====
`timescale 1ns/1ps

module miner_top #(
	parameter int NUM_LANES = 16,
	localparam int LANE_W = $clog2(NUM_LANES)
) (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic [3:0]                    s_axil_awaddr_i,
	input  logic                          s_axil_awvalid_i,
	output logic                          s_axil_awready_o,
	input  logic [31:0]                   s_axil_wdata_i,
	input  logic [3:0]                    s_axil_wstrb_i,
	input  logic                          s_axil_wvalid_i,
	output logic                          s_axil_wready_o,
	output logic [1:0]                    s_axil_bresp_o,
	output logic                          s_axil_bvalid_o,
	input  logic                          s_axil_bready_i,
	input  logic [3:0]                    s_axil_araddr_i,
	input  logic                          s_axil_arvalid_i,
	output logic                          s_axil_arready_o,
	output logic [31:0]                   s_axil_rdata_o,
	output logic [1:0]                    s_axil_rresp_o,
	output logic                          s_axil_rvalid_o,
	input  logic                          s_axil_rready_i,
	output logic                          work_valid_o,
	input  logic                          work_ready_i,
	output logic [miner_pkg::STATE_W-1:0] work_state_o,
	output logic [LANE_W-1:0]             work_lane_o,
	output logic [miner_pkg::NONCE_W-1:0] work_nonce_o,
	output logic [miner_pkg::SEQ_W-1:0]   work_seq_o,
	output logic                          work_first_o
);
	import miner_pkg::*;

	// register block to loader
	logic chunk_valid;
	logic [CHUNK_W-1:0] chunk_data;
	logic chunk_ready;
	logic [5:0] chunk_count;
	logic bcast_active;
	logic block_done_pulse;

	// loader to dispatch
	logic bcast_valid;
	logic bcast_ready;
	logic [STATE_W-1:0] bcast_state;
	logic [LANE_W-1:0] bcast_lane;
	logic bcast_first;

	// host registers, they also hold back the host until the loader takes a byte
	miner_regs miner_regs_i (
		.clk,
		.reset_i,
		.s_axil_awaddr_i,
		.s_axil_awvalid_i,
		.s_axil_awready_o,
		.s_axil_wdata_i,
		.s_axil_wstrb_i,
		.s_axil_wvalid_i,
		.s_axil_wready_o,
		.s_axil_bresp_o,
		.s_axil_bvalid_o,
		.s_axil_bready_i,
		.s_axil_araddr_i,
		.s_axil_arvalid_i,
		.s_axil_arready_o,
		.s_axil_rdata_o,
		.s_axil_rresp_o,
		.s_axil_rvalid_o,
		.s_axil_rready_i,
		.chunk_valid_o(chunk_valid),
		.chunk_data_o(chunk_data),
		.chunk_ready_i(chunk_ready),
		.chunk_count_i(chunk_count),
		.bcast_active_i(bcast_active),
		.block_done_i(block_done_pulse)
	);

	// byte assembly and per lane broadcast
	block_storage #(
		.NUM_LANES(NUM_LANES)
	) block_storage_i (
		.clk,
		.reset_i,
		.chunk_valid_i(chunk_valid),
		.chunk_data_i(chunk_data),
		.chunk_ready_o(chunk_ready),
		.chunk_count_o(chunk_count),
		.bcast_active_o(bcast_active),
		.block_done_o(block_done_pulse),
		.bcast_valid_o(bcast_valid),
		.bcast_ready_i(bcast_ready),
		.bcast_state_o(bcast_state),
		.bcast_lane_o(bcast_lane),
		.bcast_first_o(bcast_first)
	);

	// work items toward the hash cores
	work_dispatch #(
		.NUM_LANES(NUM_LANES)
	) work_dispatch_i (
		.clk,
		.reset_i,
		.bcast_valid_i(bcast_valid),
		.bcast_ready_o(bcast_ready),
		.bcast_state_i(bcast_state),
		.bcast_lane_i(bcast_lane),
		.bcast_first_i(bcast_first),
		.work_valid_o,
		.work_ready_i,
		.work_state_o,
		.work_lane_o,
		.work_nonce_o,
		.work_seq_o,
		.work_first_o
	);

endmodule

// ==== tb_axil_tasks.svh ====
// address and data are offered together and each drops once it is taken
task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] bresp);
	int cycles;
	logic aw_done;
	logic w_done;
	@(negedge clk);
	s_axil_awaddr_i = addr;
	s_axil_awvalid_i = 1'b1;
	s_axil_wdata_i = data;
	s_axil_wstrb_i = 4'hf;
	s_axil_wvalid_i = 1'b1;
	aw_done = 1'b0;
	w_done = 1'b0;
	cycles = 0;
	while (!(aw_done && w_done)) begin
		@(posedge clk);
		aw_done = aw_done || (s_axil_awvalid_i && s_axil_awready_o);
		w_done = w_done || (s_axil_wvalid_i && s_axil_wready_o);
		@(negedge clk);
		s_axil_awvalid_i = !aw_done;
		s_axil_wvalid_i = !w_done;
		cycles++;
		if (!(aw_done && w_done) && cycles > TIMEOUT_CYCLES) begin
			abort_run("write address or data was never accepted");
		end
	end
	// a chunk write only answers once the loader has taken the byte
	cycles = 0;
	while (!s_axil_bvalid_o) begin
		@(negedge clk);
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			abort_run("write response never arrived");
		end
	end
	// the response is left waiting one cycle before bready goes high
	@(negedge clk);
	bresp = s_axil_bresp_o;
	s_axil_bready_i = 1'b1;
	@(negedge clk);
	s_axil_bready_i = 1'b0;
endtask

task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] rresp);
	int cycles;
	logic taken;
	@(negedge clk);
	s_axil_araddr_i = addr;
	s_axil_arvalid_i = 1'b1;
	taken = 1'b0;
	cycles = 0;
	while (!taken) begin
		@(posedge clk);
		taken = s_axil_arready_o;
		@(negedge clk);
		cycles++;
		if (!taken && cycles > TIMEOUT_CYCLES) begin
			abort_run("read address was never accepted");
		end
	end
	s_axil_arvalid_i = 1'b0;
	cycles = 0;
	while (!s_axil_rvalid_o) begin
		@(negedge clk);
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			abort_run("read data never arrived");
		end
	end
	// read data also waits one cycle before rready goes high
	@(negedge clk);
	data = s_axil_rdata_o;
	rresp = s_axil_rresp_o;
	s_axil_rready_i = 1'b1;
	@(negedge clk);
	s_axil_rready_i = 1'b0;
endtask

// ==== tb_miner_top.sv ====
`timescale 1ns/1ps

module tb_miner_top;
	import miner_pkg::*;

	localparam int NUM_LANES = 16;
	localparam int LANE_W = $clog2(NUM_LANES);
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset_i;
	logic [3:0] s_axil_awaddr_i;
	logic s_axil_awvalid_i;
	logic s_axil_awready_o;
	logic [31:0] s_axil_wdata_i;
	logic [3:0] s_axil_wstrb_i;
	logic s_axil_wvalid_i;
	logic s_axil_wready_o;
	logic [1:0] s_axil_bresp_o;
	logic s_axil_bvalid_o;
	logic s_axil_bready_i;
	logic [3:0] s_axil_araddr_i;
	logic s_axil_arvalid_i;
	logic s_axil_arready_o;
	logic [31:0] s_axil_rdata_o;
	logic [1:0] s_axil_rresp_o;
	logic s_axil_rvalid_o;
	logic s_axil_rready_i;
	logic work_valid_o;
	logic work_ready_i = 1'b0;
	logic [STATE_W-1:0] work_state_o;
	logic [LANE_W-1:0] work_lane_o;
	logic [NONCE_W-1:0] work_nonce_o;
	logic [SEQ_W-1:0] work_seq_o;
	logic work_first_o;

	int check_errors;
	int sb_errors;
	int stall_errors;
	int bhold_errors;
	int rhold_errors;
	int test_start_errors;
	int tests_run;
	int tests_failed;
	string test_name;
	integer seed;
	// 0 holds the cores off, 1 takes every item, 2 takes items at random
	int ready_mode;
	logic [31:0] ready_rnd;
	int block_idx;
	int sb_head;
	logic [CHUNK_W-1:0] cur_bytes [NUM_CHUNKS];
	logic [STATE_W-1:0] cur_state;
	logic [STATE_W-1:0] exp_state_q [$];
	logic [LANE_W-1:0] exp_lane_q [$];
	logic [SEQ_W-1:0] exp_seq_q [$];
	logic write_done;
	logic [31:0] rdata;
	logic [1:0] resp;

	miner_top #(
		.NUM_LANES(NUM_LANES)
	) miner_top_i (.*);

	always #10 clk = ~clk;

	`include "tb_axil_tasks.svh"

	function automatic int total_errors();
		return check_errors + sb_errors + stall_errors + bhold_errors + rhold_errors;
	endfunction

	// prints an error line on a mismatch and reports whether the values agree
	function automatic bit field_ok(input string what, input logic [STATE_W-1:0] expected,
			input logic [STATE_W-1:0] actual);
		assert (actual === expected) else begin
			$display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		end
		return actual === expected;
	endfunction

	task automatic expect_eq(input string what, input logic [STATE_W-1:0] expected,
			input logic [STATE_W-1:0] actual);
		if (!field_ok(what, expected, actual)) begin
			check_errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s during %s", why, test_name);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed + 1,
			total_errors());
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = total_errors();
	endtask

	task automatic finish_test();
		int errs;
		errs = total_errors() - test_start_errors;
		tests_run++;
		if (errs == 0) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, errs);
		end
	endtask

	// chunk k of a random block is the k-th byte from the top of the state
	task automatic make_block();
		logic [31:0] rnd;
		for (int k = 0; k < NUM_CHUNKS; k++) begin
			rnd = $random(seed);
			cur_bytes[k] = rnd[7:0];
			cur_state[STATE_W - 1 - CHUNK_W * k -: CHUNK_W] = rnd[7:0];
		end
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			exp_state_q.push_back(cur_state);
			exp_lane_q.push_back(LANE_W'(lane));
			exp_seq_q.push_back(SEQ_W'(block_idx));
		end
		block_idx++;
	endtask

	task automatic write_chunks(input int first, input int last);
		logic [1:0] bresp;
		for (int k = first; k <= last; k++) begin
			axil_write(ADDR_CHUNK, {24'd0, cur_bytes[k]}, bresp);
			expect_eq("chunk write response", '0, STATE_W'(bresp));
		end
	endtask

	// every expected item has to come out and a few idle cycles after that catch extras
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (sb_head < exp_lane_q.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				abort_run("work items never reached the output");
			end
		end
		repeat (4) @(negedge clk);
	endtask

	always @(negedge clk) begin
		if (ready_mode == 2) begin
			ready_rnd = $random(seed);
			work_ready_i <= ready_rnd[0];
		end else begin
			work_ready_i <= (ready_mode == 1);
		end
	end

	// each accepted item is held against the oldest expected one
	always @(posedge clk) begin
		logic [LANE_W-1:0] lane;
		bit item_ok;
		if (!reset_i && work_valid_o && work_ready_i) begin
			if (sb_head >= exp_lane_q.size()) begin
				$display("unexpected work item for lane %0d during %s", work_lane_o, test_name);
				sb_errors++;
			end else begin
				lane = exp_lane_q[sb_head];
				item_ok = field_ok("state", exp_state_q[sb_head], work_state_o);
				item_ok &= field_ok("lane", STATE_W'(lane), STATE_W'(work_lane_o));
				// each lane starts at its share of the 2^32 nonce space
				item_ok &= field_ok("nonce",
					STATE_W'(NONCE_W'((64'(lane) << NONCE_W) / NUM_LANES)),
					STATE_W'(work_nonce_o));
				item_ok &= field_ok("first", STATE_W'(lane == '0), STATE_W'(work_first_o));
				item_ok &= field_ok("seq", STATE_W'(exp_seq_q[sb_head]), STATE_W'(work_seq_o));
				if (!item_ok) begin
					sb_errors++;
				end
				sb_head++;
			end
		end
	end

	payload_stable: assert property (@(posedge clk) disable iff (reset_i)
		(work_valid_o && !work_ready_i) |=> (work_valid_o && $stable(work_state_o)
		&& $stable(work_lane_o) && $stable(work_nonce_o) && $stable(work_seq_o)
		&& $stable(work_first_o)))
		else begin
			$display("work item changed or vanished while the cores held it off");
			stall_errors++;
		end

	bvalid_held: assert property (@(posedge clk) disable iff (reset_i)
		(s_axil_bvalid_o && !s_axil_bready_i) |=> s_axil_bvalid_o)
		else begin
			$display("write response dropped before the host took it");
			bhold_errors++;
		end

	rvalid_held: assert property (@(posedge clk) disable iff (reset_i)
		(s_axil_rvalid_o && !s_axil_rready_i) |=> s_axil_rvalid_o)
		else begin
			$display("read data dropped before the host took it");
			rhold_errors++;
		end

	initial begin
		seed = 71351;
		clk = 1'b0;
		reset_i = 1'b1;
		s_axil_awaddr_i = '0;
		s_axil_awvalid_i = 1'b0;
		s_axil_wdata_i = '0;
		s_axil_wstrb_i = '0;
		s_axil_wvalid_i = 1'b0;
		s_axil_bready_i = 1'b0;
		s_axil_araddr_i = '0;
		s_axil_arvalid_i = 1'b0;
		s_axil_rready_i = 1'b0;
		ready_mode = 0;
		block_idx = 0;
		sb_head = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "reset";
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		start_test("reset_state");
		expect_eq("work_valid", '0, STATE_W'(work_valid_o));
		expect_eq("bvalid", '0, STATE_W'(s_axil_bvalid_o));
		expect_eq("rvalid", '0, STATE_W'(s_axil_rvalid_o));
		axil_read(ADDR_STATUS, rdata, resp);
		expect_eq("loader ready", STATE_W'(1'b1), STATE_W'(rdata[0]));
		expect_eq("chunk count", '0, STATE_W'(rdata[13:8]));
		finish_test();

		start_test("block_ready_high");
		ready_mode = 1;
		make_block();
		write_chunks(0, NUM_CHUNKS - 1);
		wait_drain();
		finish_test();

		start_test("block_ready_random");
		ready_mode = 2;
		make_block();
		write_chunks(0, NUM_CHUNKS - 1);
		wait_drain();
		finish_test();

		// this block stays stalled in the broadcast for the next test
		start_test("partial_status");
		ready_mode = 0;
		make_block();
		write_chunks(0, 19);
		axil_read(ADDR_STATUS, rdata, resp);
		expect_eq("chunk count", STATE_W'(6'd20), STATE_W'(rdata[13:8]));
		expect_eq("loader ready", STATE_W'(1'b1), STATE_W'(rdata[0]));
		write_chunks(20, NUM_CHUNKS - 1);
		finish_test();

		start_test("write_during_broadcast");
		make_block();
		write_done = 1'b0;
		fork
			begin
				write_chunks(0, 0);
				write_done = 1'b1;
			end
			begin
				// the loader is stuck on a lane, so the first byte cannot be taken yet
				repeat (40) @(negedge clk);
				expect_eq("write still open", '0, STATE_W'(write_done));
				axil_read(ADDR_STATUS, rdata, resp);
				expect_eq("broadcast active", STATE_W'(1'b1), STATE_W'(rdata[16]));
				ready_mode = 2;
			end
		join
		axil_read(ADDR_BLOCKS, rdata, resp);
		expect_eq("blocks done", STATE_W'(32'd3), STATE_W'(rdata));
		write_chunks(1, NUM_CHUNKS - 1);
		wait_drain();
		axil_read(ADDR_BLOCKS, rdata, resp);
		expect_eq("blocks done", STATE_W'(32'd4), STATE_W'(rdata));
		finish_test();

		start_test("unmapped_read");
		axil_read(4'hc, rdata, resp);
		expect_eq("unmapped data", '0, STATE_W'(rdata));
		expect_eq("unmapped resp", '0, STATE_W'(resp));
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0 && tests_failed == 0 && sb_head == exp_lane_q.size()) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
miner_pkg.sv
miner_regs.sv
block_storage.sv
work_dispatch.sv
miner_top.sv
tb_miner_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the fail message
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_miner_top \
	-f sources.f -o sim_miner > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_miner > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
